// File: test/test_patterns.txt
# bank address kind data, all hex; kind 0 closed bank, 1 row hit, 2 row miss
# data is the 32-bit result, second burst word in the upper half
0 000A10 0 504B504A
0 000A20 1 507B507A
0 0013FF 2 485A49A5
1 200700 0 1D5B1D5A
2 000003 0 DA5EDA59
3 003EAB 0 A4F6A4F1
1 2007FE 1 1DA51DA4
1 000401 2 1E581E5B

// File: build.f
+incdir+src
src/sdram_rd_pkg.sv
src/sdram_bank_fsm.sv
src/sdram_cmd_arbiter.sv
src/sdram_rdata.sv
src/sdram_rd_ctrl.sv
test/sdram_model.sv
test/tb_sdram_rd_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdram_rd_ctrl
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= build.f

SRCS := $(wildcard src/*.sv src/*.svh test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_sdram_rd_ctrl.sv
// testbench for the SDRAM read controller, replays test_patterns.txt then runs concurrent and random reads
`default_nettype none

`include "sdram_rd_defs.svh"

module tb_sdram_rd_ctrl import sdram_rd_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                                     clk;
    logic                                     rst;
    logic        [`SDRAM_NBANK-1:0]           rd;
    logic        [`SDRAM_NBANK-1:0][`SDRAM_AW-1:0] addr;
    logic        [`SDRAM_NBANK-1:0]           ack;
    logic        [`SDRAM_NBANK-1:0]           rdy;
    sdram_data_t [`SDRAM_NBANK-1:0]           rdata;
    sdram_cmd_t                               cmd;
    logic        [`SDRAM_ROW-1:0]             sdram_a;
    bank_idx_t                                ba;
    sdram_word_t                              dq;
    logic                                     model_bad;

    sdram_cmd_t            cmd_log [$];   // non-NOP commands on the bus
    logic [`SDRAM_ROW-1:0] a_log   [$];
    bank_idx_t             ba_log  [$];
    logic [`SDRAM_AW-1:0]  addr_list [`SDRAM_NBANK][16];
    integer                seed;
    int                    fd;
    int                    n;
    int                    n_cmd;    // commands expected for one pattern read
    string                 line;
    logic [31:0]           p_bank;
    logic [31:0]           p_addr;
    logic [31:0]           p_kind;   // 0 closed, 1 hit, 2 miss
    logic [31:0]           p_data;
    sdram_data_t           got;
    logic [`SDRAM_NBANK-1:0] exp_ack;

    sdram_rd_ctrl sdram_rd_ctrl_i (
        .clk(clk), .rst(rst), .rd(rd), .addr(addr), .ack(ack), .rdy(rdy), .rdata(rdata),
        .cmd(cmd), .sdram_a(sdram_a), .ba(ba), .dq(dq)
    );

    sdram_model model_i (
        .clk(clk), .rst(rst), .cmd(cmd), .a(sdram_a), .ba(ba), .dq(dq), .bad(model_bad)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input sdram_data_t exp, input sdram_data_t act);
        if (exp !== act) fail_run($sformatf("Error %s exp %h got %h", name, exp, act));
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_t exp, input sdram_cmd_t act);
        if (exp !== act) fail_run($sformatf("Error %s exp %h got %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input logic [`SDRAM_ROW-1:0] exp,
                              input logic [`SDRAM_ROW-1:0] act);
        if (exp !== act) fail_run($sformatf("Error %s exp %h got %h", name, exp, act));
    endtask

    task automatic check_bank(input string name, input bank_idx_t exp, input bank_idx_t act);
        if (exp !== act) fail_run($sformatf("Error %s exp %h got %h", name, exp, act));
    endtask

    task automatic check_flags(input string name, input logic [`SDRAM_NBANK-1:0] exp,
                               input logic [`SDRAM_NBANK-1:0] act);
        if (exp !== act) fail_run($sformatf("Error %s exp %h got %h", name, exp, act));
    endtask

    // data rule, low word at the column and high word at column+1
    function automatic sdram_data_t expected_data(input int b, input logic [`SDRAM_AW-1:0] ad);
        logic [`SDRAM_ROW-1:0] r;
        logic [`SDRAM_COL-1:0] c;
        logic [`SDRAM_COL-1:0] c1;
        r  = ad[`SDRAM_AW-1 -: `SDRAM_ROW];
        c  = ad[`SDRAM_COL-1:0];
        c1 = c + 1'b1;
        return {{b[1:0], r[4:0], c1} ^ 16'h5a5a, {b[1:0], r[4:0], c} ^ 16'h5a5a};
    endfunction

    task automatic read_bank(input int b, input logic [`SDRAM_AW-1:0] ad,
                             output sdram_data_t result);
        int t;
        t = 0;
        addr[b] = ad;
        rd[b]   = 1'b1;
        @(negedge clk);
        while (!ack[b]) begin
            t++;
            if (t >= 200) fail_run($sformatf("no ack from bank %0d within 200 cycles", b));
            @(negedge clk);
        end
        @(posedge clk);
        #1 rd[b] = 1'b0;
        t = 0;
        @(negedge clk);
        while (!rdy[b]) begin
            t++;
            if (t >= 200) fail_run($sformatf("no rdy from bank %0d within 200 cycles", b));
            @(negedge clk);
        end
        @(posedge clk);
        #1 result = rdata[b];   // registered one cycle after rdy
    endtask

    task automatic bank_stream(input int b, input int first, input int count);
        sdram_data_t r;
        for (int i = first; i < first + count; i++) begin
            read_bank(b, addr_list[b][i], r);
            check_data($sformatf("rdata[%0d]", b), expected_data(b, addr_list[b][i]), r);
        end
    endtask

    task automatic expect_cmd(input int idx, input sdram_cmd_t c, input logic [`SDRAM_ROW-1:0] a,
                              input int b);
        check_cmd("cmd", c, cmd_log[idx]);
        check_addr("sdram_a", a, a_log[idx]);
        check_bank("ba", bank_idx_t'(b), ba_log[idx]);
    endtask

    always @(negedge clk) begin
        if (!rst && cmd != CMD_NOP) begin
            cmd_log.push_back(cmd);
            a_log.push_back(sdram_a);
            ba_log.push_back(ba);
        end
        if (!rst) begin
            exp_ack = '0;
            if (cmd == CMD_READ) exp_ack[ba] = 1'b1;   // ack only from the bank on the bus
            check_flags("ack", exp_ack, ack);
        end
        if (!rst && model_bad) fail_run("SDRAM model flagged an illegal command");
    end

    initial begin
        seed = 34197;
        clk  = 1'b0;
        rst  = 1'b1;
        rd   = '0;
        addr = '0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        // idle bus after reset
        repeat (10) begin
            @(negedge clk);
            check_cmd("cmd", CMD_NOP, cmd);
            if (ack !== '0 || rdy !== '0) fail_run("ack or rdy pulsed with no read pending");
        end
        @(posedge clk);
        #1;

        fd = $fopen("test/test_patterns.txt", "r");
        if (fd == 0) fail_run("could not open test/test_patterns.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue;
            if ($sscanf(line, "%h %h %h %h", p_bank, p_addr, p_kind, p_data) != 4) continue;
            case (p_kind)
                0: n_cmd = 2;   // ACTIVE, READ
                1: n_cmd = 1;   // READ only
                2: n_cmd = 3;   // PRECHARGE, ACTIVE, READ
                default: fail_run($sformatf("unknown access kind %0d in pattern file", p_kind));
            endcase
            cmd_log.delete();
            a_log.delete();
            ba_log.delete();
            read_bank(p_bank, p_addr[`SDRAM_AW-1:0], got);
            check_data("rdata", p_data, got);
            if (cmd_log.size() != n_cmd)
                fail_run($sformatf("bank %0d read saw %0d commands, wanted %0d",
                                   p_bank, cmd_log.size(), n_cmd));
            if (p_kind == 2) expect_cmd(0, CMD_PRECHARGE, '0, p_bank);
            if (p_kind != 1)
                expect_cmd(n_cmd - 2, CMD_ACTIVE, p_addr[`SDRAM_AW-1 -: `SDRAM_ROW], p_bank);
            expect_cmd(n_cmd - 1, CMD_READ, `SDRAM_ROW'(p_addr[`SDRAM_COL-1:0]), p_bank);
        end
        $fclose(fd);

        // one fixed read per bank, then random streams
        for (int b = 0; b < `SDRAM_NBANK; b++) begin
            addr_list[b][0] = {`SDRAM_ROW'(13'h40 + b), `SDRAM_COL'(b * 3)};
            for (int i = 1; i < 16; i++) begin
                addr_list[b][i] = {`SDRAM_ROW'($random(seed) & 3), `SDRAM_COL'($random(seed))};
            end
        end
        for (int b = 0; b < `SDRAM_NBANK; b++) begin
            fork
                automatic int bb = b;
                bank_stream(bb, 0, 1);
            join_none
        end
        wait fork;
        for (int b = 0; b < `SDRAM_NBANK; b++) begin
            fork
                automatic int bb = b;
                bank_stream(bb, 1, 15);
            join_none
        end
        wait fork;

        repeat (5) @(posedge clk);
        if (model_bad) begin
            $display("Test failures found");
            $fatal(1);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/sdram_model.sv
// behavioral SDRAM read model for the testbench, checks command timing and returns address-derived data
`default_nettype none

`include "sdram_rd_defs.svh"

module sdram_model import sdram_rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_cmd_t            cmd,
    input  logic [`SDRAM_ROW-1:0] a,
    input  bank_idx_t             ba,
    output sdram_word_t           dq,
    output logic                  bad    // sticky, set on any illegal command
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                  is_open  [`SDRAM_NBANK];
    logic [`SDRAM_ROW-1:0] open_row [`SDRAM_NBANK];
    int                    act_cyc  [`SDRAM_NBANK];
    int                    pre_cyc  [`SDRAM_NBANK];
    int                    last_act;
    int                    last_read;
    int                    cyc;
    sdram_word_t           nxt1;     // CAS latency pipeline
    sdram_word_t           nxt2;

    // {bank, low 5 row bits, column} scrambled
    function automatic sdram_word_t word_at(bank_idx_t b, logic [`SDRAM_ROW-1:0] r,
                                            logic [`SDRAM_COL-1:0] c);
        return {b, r[4:0], c} ^ 16'h5a5a;
    endfunction

    task automatic flag(input string why);
        $display("sdram model: %s, bank %0d at cycle %0d", why, ba, cyc);
        bad <= 1'b1;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SDRAM_NBANK; i++) begin
                is_open[i] <= 1'b0;
                act_cyc[i] <= -100;
                pre_cyc[i] <= -100;
            end
            last_act  <= -100;
            last_read <= -100;
            cyc       <= 0;
            nxt1      <= '0;
            nxt2      <= '0;
            dq        <= '0;
            bad       <= 1'b0;
        end else begin
            cyc  <= cyc + 1;
            dq   <= nxt1;
            nxt1 <= nxt2;
            nxt2 <= '0;
            case (cmd)
                CMD_PRECHARGE: begin
                    if (!is_open[ba]) flag("PRECHARGE on a closed bank");
                    is_open[ba] <= 1'b0;
                    pre_cyc[ba] <= cyc;
                end
                CMD_ACTIVE: begin
                    if (is_open[ba]) flag("ACTIVE on a bank with an open row");
                    if (cyc - pre_cyc[ba] < 3) flag("ACTIVE before tRP");
                    if (cyc - last_act <= 2) flag("ACTIVE within tRRD of another ACTIVE");
                    is_open[ba]  <= 1'b1;
                    open_row[ba] <= a;
                    act_cyc[ba]  <= cyc;
                    last_act     <= cyc;
                end
                CMD_READ: begin
                    if (!is_open[ba]) flag("READ on a closed bank");
                    if (cyc - act_cyc[ba] < 3) flag("READ before tRCD");
                    if (cyc - last_read < 2) flag("READ bursts overlap on dq");
                    last_read <= cyc;
                    nxt1 <= word_at(ba, open_row[ba], a[`SDRAM_COL-1:0]);
                    nxt2 <= word_at(ba, open_row[ba], a[`SDRAM_COL-1:0] + 1'b1);
                end
                CMD_NOP: ;
                default: flag("unexpected command code");
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/sdram_rd_ctrl.sv
// top level of the multi-bank SDRAM read controller, one client per bank, drives the SDRAM pins
`default_nettype none

`include "sdram_rd_defs.svh"

module sdram_rd_ctrl import sdram_rd_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic        [`SDRAM_NBANK-1:0]          rd,
    input  logic        [`SDRAM_NBANK-1:0][`SDRAM_AW-1:0] addr,
    output logic        [`SDRAM_NBANK-1:0]          ack,
    output logic        [`SDRAM_NBANK-1:0]          rdy,
    output sdram_data_t [`SDRAM_NBANK-1:0]          rdata,
    output sdram_cmd_t                              cmd,
    output logic        [`SDRAM_ROW-1:0]            sdram_a,
    output bank_idx_t                               ba,
    input  sdram_word_t                             dq
);

    logic       [`SDRAM_NBANK-1:0]                  br;
    logic       [`SDRAM_NBANK-1:0]                  bg;
    logic       [`SDRAM_NBANK-1:0]                  dst;
    logic       [`SDRAM_NBANK-1:0]                  dok;
    logic       [`SDRAM_NBANK-1:0]                  dbusy;
    logic       [`SDRAM_NBANK-1:0]                  dqm_busy;
    logic       [`SDRAM_NBANK-1:0]                  post_act;
    logic       [`SDRAM_NBANK-1:0]                  all_dbusy;
    logic       [`SDRAM_NBANK-1:0]                  all_dqm;
    logic       [`SDRAM_NBANK-1:0]                  all_act;
    sdram_cmd_t [`SDRAM_NBANK-1:0]                  bank_cmd;
    logic       [`SDRAM_NBANK-1:0][`SDRAM_ROW-1:0]  bank_a;

    generate
        for (genvar b = 0; b < `SDRAM_NBANK; b++) begin : g_bank
            sdram_bank_fsm u_bank (
                .clk       (clk),
                .rst       (rst),
                .addr      (addr[b]),
                .rd        (rd[b]),
                .bg        (bg[b]),
                .all_dbusy (all_dbusy[b]),
                .all_dqm   (all_dqm[b]),
                .all_act   (all_act[b]),
                .br        (br[b]),
                .ack       (ack[b]),
                .dst       (dst[b]),
                .dok       (dok[b]),
                .rdy       (rdy[b]),
                .dbusy     (dbusy[b]),
                .dqm_busy  (dqm_busy[b]),
                .post_act  (post_act[b]),
                .sdram_a   (bank_a[b]),
                .cmd       (bank_cmd[b])
            );
        end
    endgenerate

    sdram_cmd_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .br        (br),
        .cmd       (bank_cmd),
        .sdram_a   (bank_a),
        .dbusy     (dbusy),
        .dqm_busy  (dqm_busy),
        .post_act  (post_act),
        .bg        (bg),
        .all_dbusy (all_dbusy),
        .all_dqm   (all_dqm),
        .all_act   (all_act),
        .cmd_out   (cmd),
        .a_out     (sdram_a),
        .ba_out    (ba)
    );

    sdram_rdata u_rdata (
        .clk   (clk),
        .rst   (rst),
        .dst   (dst),
        .dok   (dok),
        .rdy   (rdy),
        .dq    (dq),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: src/sdram_rdata.sv
// assembles the two burst words of each bank into a registered 32-bit read result
`default_nettype none

`include "sdram_rd_defs.svh"

module sdram_rdata import sdram_rd_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic        [`SDRAM_NBANK-1:0]      dst,
    input  logic        [`SDRAM_NBANK-1:0]      dok,
    input  logic        [`SDRAM_NBANK-1:0]      rdy,
    input  sdram_word_t                         dq,
    output sdram_data_t [`SDRAM_NBANK-1:0]      rdata
);

    sdram_word_t [`SDRAM_NBANK-1:0] lo;        // first burst word
    logic        [`SDRAM_NBANK-1:0] wait_hi;   // second word due this cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_hi <= '0;
        end else begin
            wait_hi <= dst;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `SDRAM_NBANK; i++) begin
            if (dst[i]) lo[i] <= dq;
            if (dok[i] && wait_hi[i]) begin
                rdata[i] <= {dq, lo[i]};  // held until the next read of this bank
            end
        end
    end

    // the shared dq carries one bank's burst at a time
    a_dok_excl: assert property (@(posedge clk) disable iff (rst) $onehot0(dok));

    // rdy from the FSM lines up with the second word
    a_rdy_align: assert property (@(posedge clk) disable iff (rst)
        rdy == (dok & wait_hi));

endmodule

`default_nettype wire

// File: src/sdram_cmd_arbiter.sv
// rotating-priority grant of the SDRAM command bus and merge of the bank status flags
`default_nettype none

`include "sdram_rd_defs.svh"

module sdram_cmd_arbiter import sdram_rd_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic       [`SDRAM_NBANK-1:0]           br,
    input  sdram_cmd_t [`SDRAM_NBANK-1:0]           cmd,
    input  logic       [`SDRAM_NBANK-1:0][`SDRAM_ROW-1:0] sdram_a,
    input  logic       [`SDRAM_NBANK-1:0]           dbusy,
    input  logic       [`SDRAM_NBANK-1:0]           dqm_busy,
    input  logic       [`SDRAM_NBANK-1:0]           post_act,
    output logic       [`SDRAM_NBANK-1:0]           bg,
    output logic       [`SDRAM_NBANK-1:0]           all_dbusy,
    output logic       [`SDRAM_NBANK-1:0]           all_dqm,
    output logic       [`SDRAM_NBANK-1:0]           all_act,
    output sdram_cmd_t                              cmd_out,
    output logic       [`SDRAM_ROW-1:0]             a_out,
    output bank_idx_t                               ba_out
);

    bank_idx_t             last_bg;   // last granted bank
    bank_idx_t             gnt_idx;
    bank_idx_t             cand;
    logic                  found;
    logic [3:0]            cmd_or;
    logic [`SDRAM_ROW-1:0] a_or;

    // search starts at the bank after the last grant
    always_comb begin
        bg      = '0;
        gnt_idx = last_bg;
        found   = 1'b0;
        cand    = last_bg;
        for (int k = 1; k <= `SDRAM_NBANK; k++) begin
            cand = bank_idx_t'((int'(last_bg) + k) % `SDRAM_NBANK);
            if (!found && br[cand]) begin
                bg[cand] = 1'b1;
                gnt_idx  = cand;
                found    = 1'b1;
            end
        end
    end

    // each bank sees the flags of the others only
    always_comb begin
        for (int i = 0; i < `SDRAM_NBANK; i++) begin
            all_dbusy[i] = 1'b0;
            all_dqm[i]   = 1'b0;
            all_act[i]   = 1'b0;
            for (int j = 0; j < `SDRAM_NBANK; j++) begin
                if (j != i) begin
                    all_dbusy[i] |= dbusy[j];
                    all_dqm[i]   |= dqm_busy[j];
                    all_act[i]   |= post_act[j];
                end
            end
        end
    end

    always_comb begin
        cmd_or = '0;
        a_or   = '0;
        for (int i = 0; i < `SDRAM_NBANK; i++) begin
            if (bg[i]) begin
                cmd_or |= cmd[i];
                a_or   |= sdram_a[i];
            end
        end
    end

    assign cmd_out = found ? sdram_cmd_t'(cmd_or) : CMD_NOP;
    assign a_out   = a_or;
    assign ba_out  = gnt_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_bg <= bank_idx_t'(`SDRAM_NBANK-1);  // bank 0 first
        end else if (found) begin
            last_bg <= gnt_idx;
        end
    end

    a_bg_legal: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bg) && ((bg & ~br) == '0));

endmodule

`default_nettype wire

// File: src/sdram_bank_fsm.sv
// one-hot FSM for one SDRAM bank, opens rows and issues PRECHARGE, ACTIVE and READ when granted
`default_nettype none

`include "sdram_rd_defs.svh"

module sdram_bank_fsm import sdram_rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`SDRAM_AW-1:0]  addr,
    input  logic                  rd,
    input  logic                  bg,
    input  logic                  all_dbusy,
    input  logic                  all_dqm,
    input  logic                  all_act,
    output logic                  br,
    output logic                  ack,
    output logic                  dst,
    output logic                  dok,
    output logic                  rdy,
    output logic                  dbusy,
    output logic                  dqm_busy,
    output logic                  post_act,
    output logic [`SDRAM_ROW-1:0] sdram_a,
    output sdram_cmd_t            cmd
);

    logic                  prechd;     // bank has no open row
    logic [`SDRAM_ROW-1:0] row;        // open row
    logic [`SDRAM_ROW-1:0] addr_row;
    logic [`SDRAM_COL-1:0] addr_col;
    bank_state_t           st;
    bank_state_t           next_st;
    bank_state_t           rot_st;
    logic [1:0]            last_act;   // tRRD window
    logic                  waiting;
    logic                  row_hit;
    logic                  blocked;
    logic                  do_prech;
    logic                  do_act;
    logic                  do_read;

    assign addr_row = addr[`SDRAM_AW-1 -: `SDRAM_ROW];
    assign addr_col = addr[`SDRAM_COL-1:0];

    // states where a command may be issued
    assign waiting = st[`SDRAM_ST_IDLE] | st[`SDRAM_ST_PRE_ACT] | st[`SDRAM_ST_PRE_RD];
    assign row_hit = row == addr_row;

    // other banks hold off the command this bank needs
    assign blocked = prechd ? (all_act | all_dqm) : (row_hit & (all_dbusy | all_dqm));

    assign br       = rd & waiting & ~blocked;
    assign do_prech = br & bg & ~prechd & ~row_hit;
    assign do_act   = br & bg & prechd;
    assign do_read  = br & bg & ~prechd & row_hit;

    assign ack      = do_read;
    assign dst      = st[`SDRAM_ST_DST];
    assign dok      = |st[`SDRAM_ST_RDY:`SDRAM_ST_DST];
    assign rdy      = st[`SDRAM_ST_RDY];
    assign dbusy    = st[`SDRAM_ST_READ];  // a READ now would overlap our second word
    assign dqm_busy = |st[`SDRAM_ST_RDY-2:`SDRAM_ST_READ];
    assign post_act = |last_act;

    assign rot_st = {st[`SDRAM_STW-2:0], st[`SDRAM_STW-1]};

    always_comb begin
        if (do_act) begin
            next_st = bank_state_t'(1) << `SDRAM_ST_ACT;
        end else if (do_read) begin
            next_st = bank_state_t'(1) << `SDRAM_ST_READ;
        end else if (do_prech || !waiting) begin
            next_st = rot_st;  // count off tRP, tRCD and the data phase
        end else begin
            next_st = st;
        end
    end

    always_comb begin
        cmd     = CMD_NOP;
        sdram_a = '0;
        if (do_prech) begin
            cmd = CMD_PRECHARGE;  // A10 low, this bank only
        end else if (do_act) begin
            cmd     = CMD_ACTIVE;
            sdram_a = addr_row;
        end else if (do_read) begin
            cmd     = CMD_READ;
            sdram_a = {{(`SDRAM_ROW-`SDRAM_COL){1'b0}}, addr_col};  // no auto precharge
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= bank_state_t'(1) << `SDRAM_ST_IDLE;
            prechd   <= 1'b1;
            last_act <= '0;
        end else begin
            st       <= next_st;
            last_act <= {do_act, last_act[1]};
            if (do_act) begin
                prechd <= 1'b0;
            end else if (do_prech) begin
                prechd <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_act) row <= addr_row;
    end

    a_st_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(st));

    a_one_cmd: assert property (@(posedge clk) disable iff (rst)
        $onehot0({do_prech, do_act, do_read}));

endmodule

`default_nettype wire

// File: src/sdram_rd_pkg.sv
// shared command, data and bank types for the SDRAM read controller; import where used
`default_nettype none

`include "sdram_rd_defs.svh"

package sdram_rd_pkg;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1000  // chip deselected
    } sdram_cmd_t;

    typedef logic [15:0] sdram_word_t;

    // first burst word in the low half
    typedef logic [2*$bits(sdram_word_t)-1:0] sdram_data_t;

    typedef logic [$clog2(`SDRAM_NBANK)-1:0] bank_idx_t;

    typedef logic [`SDRAM_STW-1:0] bank_state_t;  // one-hot bank FSM state

endpackage

`default_nettype wire

// File: src/sdram_rd_defs.svh
// address split, bank count and one-hot state positions for the SDRAM read controller; include where needed
`ifndef SDRAM_RD_DEFS_SVH
`define SDRAM_RD_DEFS_SVH

`define SDRAM_AW    22  // client word address
`define SDRAM_ROW   13
`define SDRAM_COL   9
`define SDRAM_NBANK 4
`define SDRAM_CL    2   // CAS latency, HF timing only

// one-hot positions of the bank FSM
// the READ position is the cycle after the READ command
`define SDRAM_ST_IDLE    0
`define SDRAM_ST_PRE_ACT 3                                   // tRP of 3 cycles
`define SDRAM_ST_ACT     (`SDRAM_ST_PRE_ACT + 1)
`define SDRAM_ST_PRE_RD  (`SDRAM_ST_ACT + 2)                 // tRCD of 3 cycles
`define SDRAM_ST_READ    (`SDRAM_ST_PRE_RD + 1)
`define SDRAM_ST_DST     (`SDRAM_ST_READ + `SDRAM_CL - 1)    // first burst word on dq
`define SDRAM_ST_RDY     (`SDRAM_ST_DST + 1)                 // burst length 2
`define SDRAM_STW        (`SDRAM_ST_RDY + 1)

`endif
